// File: design/trigin_pkg.sv
package trigin_pkg;

  // Local time fields
  typedef logic [63:0] seconds_t;
  typedef logic [31:0] cycles_t;

  // Wishbone bus fields
  typedef logic [31:0] wb_adr_t;
  typedef logic [31:0] wb_dat_t;
  typedef logic [3:0]  wb_sel_t;

  // Master to slave
  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
    wb_sel_t sel;
    // Write data
    wb_dat_t dat;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic    ack;
    logic    stall;
    // Read data
    wb_dat_t dat;
  } wb_rsp_t;

  // Timebase rate, kept small so a second boundary is reachable in simulation
  localparam cycles_t CYCLES_PER_SEC = 32'd1000;

  // Register byte offsets, only bits 4:2 are decoded
  localparam wb_adr_t REG_CTRL       = 32'h0000_0000;
  localparam wb_adr_t REG_SECONDS_HI = 32'h0000_0008;
  localparam wb_adr_t REG_SECONDS_LO = 32'h0000_000C;
  localparam wb_adr_t REG_CYCLES     = 32'h0000_0010;

  // Enable bit in the control word
  localparam int CTRL_ENABLE_BIT = 1;

endpackage

// File: design/trigin_timebase.sv
`timescale 1ns/100ps

module trigin_timebase
  (
    input  logic                clk_i,
    input  logic                rst_i,

    // Local time since reset
    output trigin_pkg::seconds_t now_seconds_o,
    output trigin_pkg::cycles_t  now_cycles_o
  );

  trigin_pkg::seconds_t seconds_q;
  trigin_pkg::cycles_t  cycles_q;
  logic                 sec_wrap;

  // Last cycle of the current second
  assign sec_wrap = (cycles_q == trigin_pkg::CYCLES_PER_SEC - 32'd1);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      cycles_q  <= '0;
      seconds_q <= '0;
    end
    else
    begin
      if (sec_wrap)
      begin
        cycles_q  <= '0;
        seconds_q <= seconds_q + 64'd1;
      end
      else
        cycles_q <= cycles_q + 32'd1;
    end
  end

  assign now_seconds_o = seconds_q;
  assign now_cycles_o  = cycles_q;

endmodule

// File: design/trigin_stamp.sv
`timescale 1ns/100ps

module trigin_stamp
  (
    input  logic                 clk_i,
    input  logic                 rst_i,

    // Asynchronous trigger level
    input  logic                 trig_i,

    // Live time from the timebase
    input  trigin_pkg::seconds_t now_seconds_i,
    input  trigin_pkg::cycles_t  now_cycles_i,

    // Control register write
    input  logic                 ctrl_wr_i,
    input  logic                 ctrl_enable_i,

    // Armed flag and captured time
    output logic                 enable_o,
    output trigin_pkg::seconds_t seconds_o,
    output trigin_pkg::cycles_t  cycles_o,

    output logic                 fire_o
  );

  logic                 trig_meta;
  logic                 trig_sync;
  logic                 trig_prev;
  logic                 edge_q;
  logic                 armed_q;
  logic                 fire;
  trigin_pkg::seconds_t seconds_q;
  trigin_pkg::cycles_t  cycles_q;

  // Two-flop synchronizer, then a registered rising edge
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      trig_meta <= 1'b0;
      trig_sync <= 1'b0;
      trig_prev <= 1'b0;
      edge_q    <= 1'b0;
    end
    else
    begin
      trig_meta <= trig_i;
      trig_sync <= trig_meta;
      trig_prev <= trig_sync;
      edge_q    <= trig_sync & ~trig_prev;
    end
  end

  // A software write in the same cycle wins over the edge
  assign fire = edge_q & armed_q & ~ctrl_wr_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      armed_q <= 1'b0;
    else if (ctrl_wr_i)
      armed_q <= ctrl_enable_i;
    else if (fire)
      armed_q <= 1'b0;
  end

  // Both fields latched together so they stay coherent
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      seconds_q <= '0;
      cycles_q  <= '0;
    end
    else if (fire)
    begin
      seconds_q <= now_seconds_i;
      cycles_q  <= now_cycles_i;
    end
  end

  assign enable_o  = armed_q;
  assign seconds_o = seconds_q;
  assign cycles_o  = cycles_q;
  assign fire_o    = fire;

endmodule

// File: design/trigin_regs.sv
`timescale 1ns/100ps

module trigin_regs
  (
    input  logic                 clk_i,
    input  logic                 rst_i,

    // Pipelined Wishbone slave port
    input  trigin_pkg::wb_req_t  wb_req_i,
    output trigin_pkg::wb_rsp_t  wb_rsp_o,

    // Control register, enable is cleared by hardware on trigger
    input  logic                 ctrl_enable_i,
    output logic                 ctrl_enable_o,
    output logic                 ctrl_wr_o,

    // Captured timestamp
    input  trigin_pkg::seconds_t seconds_i,
    input  trigin_pkg::cycles_t  cycles_i
  );

  logic [4:2]          adr_int;
  logic                wb_en;
  logic                rd_req_int;
  logic                wr_req_int;
  logic                wb_rip;
  logic                wb_wip;
  logic                rd_ack_int;
  logic                wr_ack_int;
  logic                ack_int;
  logic                ctrl_wreq;
  logic                rd_ack_d0;
  trigin_pkg::wb_dat_t rd_dat_d0;
  trigin_pkg::wb_dat_t rd_dat_q;
  logic                wr_req_d0;
  logic [4:2]          wr_adr_d0;
  trigin_pkg::wb_dat_t wr_dat_d0;

  // Request decode, byte selects are not used
  assign adr_int = wb_req_i.adr[4:2];
  assign wb_en   = wb_req_i.cyc & wb_req_i.stb;

  // Read in progress, stops a held read from being taken twice
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      wb_rip <= 1'b0;
    else
      wb_rip <= (wb_rip | (wb_en & ~wb_req_i.we)) & ~rd_ack_int;
  end
  assign rd_req_int = wb_en & ~wb_req_i.we & ~wb_rip;

  // Write in progress
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      wb_wip <= 1'b0;
    else
      wb_wip <= (wb_wip | (wb_en & wb_req_i.we)) & ~wr_ack_int;
  end
  assign wr_req_int = wb_en & wb_req_i.we & ~wb_wip;

  assign ack_int  = rd_ack_int | wr_ack_int;
  assign wb_rsp_o = '{ack: ack_int, stall: ~ack_int & wb_en, dat: rd_dat_q};

  // Control state
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      rd_ack_int <= 1'b0;
      wr_req_d0  <= 1'b0;
    end
    else
    begin
      rd_ack_int <= rd_ack_d0;
      wr_req_d0  <= wr_req_int;
    end
  end

  // Read data out, write request in
  always_ff @(posedge clk_i)
  begin
    rd_dat_q  <= rd_dat_d0;
    wr_adr_d0 <= adr_int;
    wr_dat_d0 <= wb_req_i.dat;
  end

  assign ctrl_enable_o = wr_dat_d0[trigin_pkg::CTRL_ENABLE_BIT];
  assign ctrl_wr_o     = ctrl_wreq;

  // Write decode, every address is acked
  always_comb
  begin
    ctrl_wreq  = 1'b0;
    wr_ack_int = wr_req_d0;
    case (wr_adr_d0)
      trigin_pkg::REG_CTRL[4:2]:
        ctrl_wreq = wr_req_d0;
      // Timestamp registers are read only
      default:
        ctrl_wreq = 1'b0;
    endcase
  end

  // Read decode, unmapped offsets read zero
  always_comb
  begin
    rd_ack_d0 = rd_req_int;
    rd_dat_d0 = '0;
    case (adr_int)
      trigin_pkg::REG_CTRL[4:2]:
        rd_dat_d0[trigin_pkg::CTRL_ENABLE_BIT] = ctrl_enable_i;
      trigin_pkg::REG_SECONDS_HI[4:2]:
        rd_dat_d0 = seconds_i[63:32];
      trigin_pkg::REG_SECONDS_LO[4:2]:
        rd_dat_d0 = seconds_i[31:0];
      trigin_pkg::REG_CYCLES[4:2]:
        rd_dat_d0 = cycles_i;
      default:
        rd_dat_d0 = '0;
    endcase
  end

endmodule

// File: design/trigin_top.sv
`timescale 1ns/100ps

module trigin_top
  (
    input  logic                clk_i,
    input  logic                rst_i,

    // Register access
    input  trigin_pkg::wb_req_t wb_req_i,
    output trigin_pkg::wb_rsp_t wb_rsp_o,

    // Trigger in, fire pulse out
    input  logic                trig_i,
    output logic                fire_o
  );

  trigin_pkg::seconds_t now_seconds;
  trigin_pkg::cycles_t  now_cycles;
  trigin_pkg::seconds_t seconds;
  trigin_pkg::cycles_t  cycles;
  logic                 ctrl_wr;
  logic                 ctrl_enable;
  logic                 enable;

  trigin_timebase i_trigin_timebase
  (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .now_seconds_o (now_seconds),
    .now_cycles_o  (now_cycles)
  );

  trigin_stamp i_trigin_stamp
  (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .trig_i        (trig_i),
    .now_seconds_i (now_seconds),
    .now_cycles_i  (now_cycles),
    .ctrl_wr_i     (ctrl_wr),
    .ctrl_enable_i (ctrl_enable),
    .enable_o      (enable),
    .seconds_o     (seconds),
    .cycles_o      (cycles),
    .fire_o        (fire_o)
  );

  trigin_regs i_trigin_regs
  (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .wb_req_i      (wb_req_i),
    .wb_rsp_o      (wb_rsp_o),
    .ctrl_enable_i (enable),
    .ctrl_enable_o (ctrl_enable),
    .ctrl_wr_o     (ctrl_wr),
    .seconds_i     (seconds),
    .cycles_i      (cycles)
  );

endmodule

// File: sim/tb_trigin.sv
`timescale 1ns/100ps

module tb_trigin;

  localparam int TIMEOUT_CYCLES = 6000;

  logic                clk_i;
  logic                rst_i;
  trigin_pkg::wb_req_t wb_req_i;
  trigin_pkg::wb_rsp_t wb_rsp_o;
  logic                trig_i;
  logic                fire_o;

  // Reference time, mirrors the timebase without wrapping
  logic [63:0] ref_count;
  int          cycle_total;
  integer      seed;

  trigin_top i_trigin_top
  (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wb_req_i (wb_req_i),
    .wb_rsp_o (wb_rsp_o),
    .trig_i   (trig_i),
    .fire_o   (fire_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    if (rst_i)
      ref_count <= '0;
    else
      ref_count <= ref_count + 64'd1;
  end

  always @(posedge clk_i)
  begin
    cycle_total <= cycle_total + 1;
    if (cycle_total >= TIMEOUT_CYCLES)
    begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Done: errors found");
      $fatal(1);
    end
  end

  task automatic stop_on_error();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_dat(input string name, input trigin_pkg::wb_dat_t got,
                           input trigin_pkg::wb_dat_t exp);
    if (got !== exp)
    begin
      $display("error: %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_seconds(input string name, input trigin_pkg::seconds_t got,
                               input trigin_pkg::seconds_t exp);
    if (got !== exp)
    begin
      $display("error: %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_cycles(input string name, input trigin_pkg::cycles_t got,
                              input trigin_pkg::cycles_t exp);
    if (got !== exp)
    begin
      $display("error: %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("error: %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  // One transfer, returns the read data and the cycles until ack
  task automatic bus_transfer(input logic we, input trigin_pkg::wb_adr_t adr,
                              input trigin_pkg::wb_dat_t wdat,
                              output trigin_pkg::wb_dat_t rdat, output int waited);
    waited = 0;
    @(posedge clk_i);
    wb_req_i <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: 4'hf, dat: wdat};
    #1;
    // Request pending without ack
    check_bit("stall", wb_rsp_o.stall, 1'b1);
    do
    begin
      @(posedge clk_i);
      #1;
      waited = waited + 1;
      if (waited > 10)
      begin
        $display("bus error: no ack within 10 cycles at address %h", adr);
        stop_on_error();
      end
    end
    while (!wb_rsp_o.ack);
    check_bit("stall", wb_rsp_o.stall, 1'b0);
    rdat = wb_rsp_o.dat;
    @(posedge clk_i);
    wb_req_i <= '0;
  endtask

  task automatic wb_write(input trigin_pkg::wb_adr_t adr, input trigin_pkg::wb_dat_t dat);
    trigin_pkg::wb_dat_t unused;
    int                  waited;
    bus_transfer(1'b1, adr, dat, unused, waited);
  endtask

  task automatic wb_read(input trigin_pkg::wb_adr_t adr, output trigin_pkg::wb_dat_t dat);
    int waited;
    bus_transfer(1'b0, adr, '0, dat, waited);
    if (waited != 1)
    begin
      $display("bus error: read ack came %0d cycles after the request", waited);
      stop_on_error();
    end
  endtask

  task automatic expect_read(input string name, input trigin_pkg::wb_adr_t adr,
                             input trigin_pkg::wb_dat_t exp);
    trigin_pkg::wb_dat_t dat;
    wb_read(adr, dat);
    check_dat(name, dat, exp);
  endtask

  // Reads the three timestamp words and compares with a reference count
  task automatic expect_stamp(input logic [63:0] count);
    trigin_pkg::wb_dat_t hi;
    trigin_pkg::wb_dat_t lo;
    trigin_pkg::wb_dat_t cyc;
    trigin_pkg::seconds_t exp_sec;
    trigin_pkg::cycles_t  exp_cyc;
    exp_sec = count / 64'(trigin_pkg::CYCLES_PER_SEC);
    exp_cyc = trigin_pkg::cycles_t'(count % 64'(trigin_pkg::CYCLES_PER_SEC));
    wb_read(trigin_pkg::REG_SECONDS_HI, hi);
    wb_read(trigin_pkg::REG_SECONDS_LO, lo);
    wb_read(trigin_pkg::REG_CYCLES, cyc);
    check_seconds("seconds", {hi, lo}, exp_sec);
    check_cycles("cycles", cyc, exp_cyc);
  endtask

  // Raises the trigger, checks fire at the detection cycle, returns that count
  task automatic pulse_trigger(input logic expect_fire, output logic [63:0] count);
    @(posedge clk_i);
    trig_i <= 1'b1;
    @(posedge clk_i);
    @(posedge clk_i);
    #1;
    check_bit("fire_o", fire_o, 1'b0);
    @(posedge clk_i);
    #1;
    check_bit("fire_o", fire_o, expect_fire);
    count = ref_count;
    @(posedge clk_i);
    #1;
    check_bit("fire_o", fire_o, 1'b0);
    @(posedge clk_i);
    trig_i <= 1'b0;
    repeat (4) @(posedge clk_i);
  endtask

  task automatic idle_random();
    int delay;
    delay = {$random(seed)} % 20;
    repeat (delay) @(posedge clk_i);
  endtask

  task automatic wait_until_count(input logic [63:0] target);
    do
    begin
      @(posedge clk_i);
      #1;
    end
    while (ref_count < target);
  endtask

  task automatic test_reset_values();
    expect_read("ctrl", trigin_pkg::REG_CTRL, '0);
    expect_read("seconds_hi", trigin_pkg::REG_SECONDS_HI, '0);
    expect_read("seconds_lo", trigin_pkg::REG_SECONDS_LO, '0);
    expect_read("cycles", trigin_pkg::REG_CYCLES, '0);
    expect_read("unmapped_04", 32'h04, '0);
    expect_read("unmapped_14", 32'h14, '0);
  endtask

  task automatic test_ctrl_access();
    wb_write(trigin_pkg::REG_CTRL, 32'h2);
    expect_read("ctrl", trigin_pkg::REG_CTRL, 32'h2);
    wb_write(trigin_pkg::REG_CTRL, 32'h0);
    expect_read("ctrl", trigin_pkg::REG_CTRL, 32'h0);
    wb_write(trigin_pkg::REG_CYCLES, 32'hdead_beef);
    expect_read("cycles", trigin_pkg::REG_CYCLES, '0);
  endtask

  task automatic test_armed_capture();
    logic [63:0] count;
    logic [63:0] ignored;
    wb_write(trigin_pkg::REG_CTRL, 32'h2);
    idle_random();
    pulse_trigger(1'b1, count);
    expect_read("ctrl", trigin_pkg::REG_CTRL, 32'h0);
    expect_stamp(count);
    // Second edge without rearming
    idle_random();
    pulse_trigger(1'b0, ignored);
    expect_stamp(count);
  endtask

  task automatic test_disarmed_edge();
    logic [63:0] count;
    logic [63:0] ignored;
    wb_write(trigin_pkg::REG_CTRL, 32'h2);
    pulse_trigger(1'b1, count);
    // Armed again, then disarmed by software before the edge
    wb_write(trigin_pkg::REG_CTRL, 32'h2);
    wb_write(trigin_pkg::REG_CTRL, 32'h0);
    idle_random();
    pulse_trigger(1'b0, ignored);
    expect_read("ctrl", trigin_pkg::REG_CTRL, 32'h0);
    expect_stamp(count);
  endtask

  task automatic test_second_boundary();
    logic [63:0] first;
    logic [63:0] second;
    logic [63:0] start;
    wait_until_count(64'd1100);
    wb_write(trigin_pkg::REG_CTRL, 32'h2);
    idle_random();
    pulse_trigger(1'b1, first);
    expect_stamp(first);
    // Two captures 400 cycles apart across the next boundary
    wait_until_count(64'd1800);
    wb_write(trigin_pkg::REG_CTRL, 32'h2);
    #1;
    start = ref_count;
    pulse_trigger(1'b1, first);
    expect_stamp(first);
    wb_write(trigin_pkg::REG_CTRL, 32'h2);
    wait_until_count(start + 64'd400);
    pulse_trigger(1'b1, second);
    expect_stamp(second);
    check_seconds("capture_interval", second - first, 64'd400);
  endtask

  initial
  begin
    seed        = 46;
    cycle_total = 0;
    rst_i       = 1'b1;
    wb_req_i    = '0;
    trig_i      = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;

    test_reset_values();
    test_ctrl_access();
    test_armed_capture();
    test_disarmed_edge();
    test_second_boundary();

    repeat (2) @(posedge clk_i);
    $display("Done: no errors");
    $finish;
  end

endmodule

// File: all.f
design/trigin_pkg.sv
design/trigin_timebase.sv
design/trigin_stamp.sv
design/trigin_regs.sv
design/trigin_top.sv
sim/tb_trigin.sv

// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_trigin
FILELIST   = all.f
PASS       = Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
